/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= exu_tb
RTL_TOP   ?= exu_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -j 0
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

run: build
	-$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/exu_tb.sv */
`default_nettype none

module exu_tb import exu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W      = 10;
  localparam int RAM_LATENCY = 1;
  localparam int TIMEOUT     = 200;

  logic     clock     = 1'b0;
  logic     rst_n     = 1'b0;
  logic     in_valid  = 1'b0;
  logic     in_ready;
  xlen_t    src1      = '0;
  xlen_t    src2      = '0;
  xlen_t    pc        = '0;
  xlen_t    imm       = '0;
  alu_op_e  alu_op    = ADD;
  brch_op_e brch_op   = BR_NONE;
  mem_op_e  mem_op    = MEM_NONE;
  src_sel_e src_sel   = SEL_REG;
  logic     out_valid;
  logic     out_ready = 1'b1;
  xlen_t    res;
  logic     zero;
  logic     bp_on     = 1'b0;
  xlen_t    rng       = 32'd23882;

  always #50 clock = ~clock;

  exu_top #(
    .ADDR_W      (ADDR_W),
    .RAM_LATENCY (RAM_LATENCY)
  ) dut_i (
    .clock       (clock),
    .i_rst_n     (rst_n),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .i_src1      (src1),
    .i_src2      (src2),
    .i_pc        (pc),
    .i_imm       (imm),
    .i_alu_op    (alu_op),
    .i_brch_op   (brch_op),
    .i_mem_op    (mem_op),
    .i_src_sel   (src_sel),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready),
    .o_res       (res),
    .o_zero      (zero)
  );

  function automatic xlen_t xorshift32(input xlen_t x);
    xlen_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sink stalls about one cycle in four
  always @(posedge clock) begin
    if (bp_on) begin
      rng       <= xorshift32(rng);
      out_ready <= rng[1:0] != 2'b00;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s is %08h, expected %08h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic run_op(input src_sel_e sel, input alu_op_e aop, input brch_op_e bop,
                        input mem_op_e mop, input xlen_t a, input xlen_t b,
                        input xlen_t pc_v, input xlen_t imm_v,
                        input xlen_t exp_res, input logic exp_zero);
    int    waited;
    logic  seen;
    src_sel  <= sel;
    alu_op   <= aop;
    brch_op  <= bop;
    mem_op   <= mop;
    src1     <= a;
    src2     <= b;
    pc       <= pc_v;
    imm      <= imm_v;
    in_valid <= 1'b1;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
      if (out_valid) begin
        abort_run("o_out_valid high before the operation was accepted");
      end
      if (!in_ready && waited >= TIMEOUT) begin
        abort_run("timeout waiting for o_in_ready");
      end
    end while (!in_ready);
    in_valid <= 1'b0;
    // cycles counted from the acceptance edge
    waited = 0;
    seen   = 1'b0;
    do begin
      @(posedge clock);
      waited++;
      if (!(out_valid && out_ready) && waited >= TIMEOUT) begin
        abort_run("timeout waiting for o_out_valid with i_out_ready");
      end
      if (out_valid && in_ready) begin
        abort_run("o_in_ready high while a result waits");
      end
      if (out_valid && !seen) begin
        seen = 1'b1;
        if (mop == MEM_NONE && waited != 1) begin
          abort_run($sformatf("ALU result came %0d cycles after acceptance, not 1", waited));
        end
      end
      // result has to hold until the sink takes it
      if (out_valid) begin
        check_word("o_res", res, exp_res);
        check_flag("o_zero", zero, exp_zero);
      end
    end while (!(out_valid && out_ready));
  endtask

  initial begin
    int         fd;
    int         n;
    int         count;
    string      line;
    logic [1:0] f_sel;
    logic [3:0] f_alu;
    logic [2:0] f_brch;
    logic [3:0] f_mem;
    xlen_t      f_src1;
    xlen_t      f_src2;
    xlen_t      f_pc;
    xlen_t      f_imm;
    xlen_t      f_res;
    logic       f_zero;
    count = 0;
    fd = $fopen("dv/exu_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open dv/exu_tests.txt");
    end
    repeat (10) @(posedge clock);
    check_flag("o_out_valid", out_valid, 1'b0);
    rst_n <= 1'b1;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_sel, f_alu, f_brch, f_mem,
                  f_src1, f_src2, f_pc, f_imm, f_res, f_zero);
      if (n != 10) begin
        abort_run($sformatf("malformed vector line: %s", line));
      end
      run_op(src_sel_e'(f_sel), alu_op_e'(f_alu), brch_op_e'(f_brch), mem_op_e'(f_mem),
             f_src1, f_src2, f_pc, f_imm, f_res, f_zero);
      count++;
      // first result is taken with the sink always ready
      bp_on <= 1'b1;
    end
    $fclose(fd);
    // the last result is offered only once
    @(posedge clock);
    check_flag("o_out_valid", out_valid, 1'b0);
    if (count == 0) begin
      abort_run("no vectors found in dv/exu_tests.txt");
    end else begin
      $display("%0d operations checked", count);
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/exu_tests.txt */
# columns, all hex: src_sel alu_op brch_op mem_op src1 src2 pc imm exp_res exp_zero
# src_sel 0 reg, 1 imm, 2 pc+4, 3 pc+imm; brch_op 2 is no branch; mem_op 0 is none
0 0 2 0 00000005 00000007 00000000 00000000 0000000c 0
0 1 2 0 00000009 00000009 00000000 00000000 00000000 1
0 2 2 0 00000001 00000024 00000000 00000000 00000010 0
0 3 2 0 ffffffff 00000001 00000000 00000000 00000001 0
0 4 2 0 ffffffff 00000001 00000000 00000000 00000000 1
0 5 2 0 f0f0f0f0 0ff00ff0 00000000 00000000 ff00ff00 0
0 6 2 0 80000000 00000004 00000000 00000000 08000000 0
0 7 2 0 80000000 00000004 00000000 00000000 f8000000 0
0 8 2 0 12340000 00005678 00000000 00000000 12345678 0
0 9 2 0 ff00ff00 0ff00ff0 00000000 00000000 0f000f00 0
1 0 2 0 00001000 deadbeef 00000000 fffffffc 00000ffc 0
1 7 2 0 fffff000 deadbeef 00000000 00000008 fffffff0 0
1 4 2 0 00000003 deadbeef 00000000 00000010 00000001 0
1 5 2 0 0000ffff deadbeef 00000000 0000ffff 00000000 1
2 0 2 0 deadbeef deadbeef 00000100 12345678 00000104 0
2 1 2 0 deadbeef deadbeef 00000004 12345678 00000000 1
3 0 2 0 deadbeef deadbeef 00000200 00000080 00000280 0
3 2 2 0 deadbeef deadbeef 00000003 0000001f 80000000 0
# branches, taken then not taken
0 1 0 0 00000005 00000005 00000000 00000000 00000001 0
0 1 0 0 00000005 00000006 00000000 00000000 00000000 1
0 1 1 0 00000005 00000006 00000000 00000000 00000001 0
0 1 1 0 00000007 00000007 00000000 00000000 00000000 1
0 1 4 0 ffffffff 00000001 00000000 00000000 00000001 0
0 1 4 0 00000001 ffffffff 00000000 00000000 00000000 1
0 1 5 0 00000001 ffffffff 00000000 00000000 00000001 0
0 1 5 0 ffffffff 00000001 00000000 00000000 00000000 1
0 1 6 0 00000001 ffffffff 00000000 00000000 00000001 0
0 1 6 0 ffffffff 00000001 00000000 00000000 00000000 1
0 1 7 0 ffffffff 00000001 00000000 00000000 00000001 0
0 1 7 0 00000001 ffffffff 00000000 00000000 00000000 1
# word at 0x100: sw, sh, sb, then loads of the merged word abcdf044
1 0 2 8 00000100 11223344 00000000 00000000 00000100 0
1 0 2 7 00000100 0000abcd 00000000 00000002 00000102 0
1 0 2 6 00000100 000000f0 00000000 00000001 00000101 0
1 0 2 3 00000100 00000000 00000000 00000000 abcdf044 0
1 0 2 2 00000100 00000000 00000000 00000002 ffffabcd 0
1 0 2 5 00000100 00000000 00000000 00000002 0000abcd 0
1 0 2 2 00000100 00000000 00000000 00000000 fffff044 0
1 0 2 1 00000100 00000000 00000000 00000001 fffffff0 0
1 0 2 4 00000100 00000000 00000000 00000001 000000f0 0
1 0 2 4 00000100 00000000 00000000 00000003 000000ab 0

/* list.f */
src/exu_pkg.sv
src/exu_alu.sv
src/exu_lsu.sv
src/exu_stage.sv
src/exu_data_ram.sv
src/exu_top.sv
dv/exu_tb.sv

/* src/exu_alu.sv */
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  xlen_t   i_a,
  input  xlen_t   i_b,
  input  alu_op_e i_op,
  output xlen_t   o_res,
  output logic    o_lt,
  output logic    o_ltu
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  // compares shared with the branch decision
  assign o_lt  = $signed(i_a) < $signed(i_b);
  assign o_ltu = i_a < i_b;

  always_comb begin
    case (i_op)
      ADD: begin
        o_res = i_a + i_b;
      end
      SUB: begin
        o_res = i_a - i_b;
      end
      SLL: begin
        o_res = i_a << shamt;
      end
      SLT: begin
        o_res = {{(XLEN-1){1'b0}}, o_lt};
      end
      SLTU: begin
        o_res = {{(XLEN-1){1'b0}}, o_ltu};
      end
      XOR: begin
        o_res = i_a ^ i_b;
      end
      SRL: begin
        o_res = i_a >> shamt;
      end
      SRA: begin
        // arithmetic shift keeps the sign bit
        o_res = $signed(i_a) >>> shamt;
      end
      OR: begin
        o_res = i_a | i_b;
      end
      AND: begin
        o_res = i_a & i_b;
      end
      default: begin
        o_res = i_a + i_b;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/exu_data_ram.sv */
`default_nettype none

module exu_data_ram import exu_pkg::*; #(
  parameter int ADDR_W      = 10,
  parameter int RAM_LATENCY = 1
) (
  input  logic       clock,
  input  logic       i_rst_n,
  input  xlen_t      i_s_axi_awaddr,
  input  logic       i_s_axi_awvalid,
  output logic       o_s_axi_awready,
  input  xlen_t      i_s_axi_wdata,
  input  logic [3:0] i_s_axi_wstrb,
  input  logic       i_s_axi_wvalid,
  output logic       o_s_axi_wready,
  output logic       o_s_axi_bvalid,
  input  logic       i_s_axi_bready,
  input  xlen_t      i_s_axi_araddr,
  input  logic       i_s_axi_arvalid,
  output logic       o_s_axi_arready,
  output xlen_t      o_s_axi_rdata,
  output logic       o_s_axi_rlast,
  output logic       o_s_axi_rvalid,
  input  logic       i_s_axi_rready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WWAIT,
    ST_BRESP,
    ST_RWAIT,
    ST_RRESP
  } ram_state_e;

  ram_state_e  state;
  logic [7:0]  wait_cnt;
  logic        wr_go;
  logic        rd_go;
  xlen_t       mem [2**ADDR_W];

  // aw and w are taken together and writes win over reads
  assign wr_go = state == ST_IDLE && i_s_axi_awvalid && i_s_axi_wvalid;
  assign rd_go = state == ST_IDLE && !i_s_axi_awvalid && i_s_axi_arvalid;

  assign o_s_axi_awready = wr_go;
  assign o_s_axi_wready  = wr_go;
  assign o_s_axi_arready = rd_go;
  assign o_s_axi_bvalid  = state == ST_BRESP;
  assign o_s_axi_rvalid  = state == ST_RRESP;
  assign o_s_axi_rlast   = 1'b1;

  always_ff @(posedge clock) begin
    if (wr_go) begin
      for (int i = 0; i < 4; i++) begin
        if (i_s_axi_wstrb[i]) begin
          mem[i_s_axi_awaddr[ADDR_W+1:2]][8*i +: 8] <= i_s_axi_wdata[8*i +: 8];
        end
      end
    end
    if (rd_go) begin
      o_s_axi_rdata <= mem[i_s_axi_araddr[ADDR_W+1:2]];
    end
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          wait_cnt <= 8'(RAM_LATENCY);
          if (wr_go) begin
            state <= ST_WWAIT;
          end else if (rd_go) begin
            state <= ST_RWAIT;
          end
        end
        ST_WWAIT, ST_RWAIT: begin
          if (wait_cnt == '0) begin
            state <= (state == ST_WWAIT) ? ST_BRESP : ST_RRESP;
          end else begin
            wait_cnt <= wait_cnt - 8'd1;
          end
        end
        ST_BRESP: if (i_s_axi_bready) state <= ST_IDLE;
        ST_RRESP: if (i_s_axi_rready) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/exu_lsu.sv */
`default_nettype none

module exu_lsu import exu_pkg::*; (
  input  logic       clock,
  input  logic       i_rst_n,
  input  logic       i_req,
  input  xlen_t      i_addr,
  input  xlen_t      i_wdata,
  input  mem_op_e    i_op,
  output logic       o_done,
  output xlen_t      o_rdata,
  output xlen_t      o_m_axi_awaddr,
  output logic       o_m_axi_awvalid,
  input  logic       i_m_axi_awready,
  output logic [7:0] o_m_axi_awlen,
  output logic [2:0] o_m_axi_awsize,
  output logic [1:0] o_m_axi_awburst,
  output xlen_t      o_m_axi_wdata,
  output logic [3:0] o_m_axi_wstrb,
  output logic       o_m_axi_wlast,
  output logic       o_m_axi_wvalid,
  input  logic       i_m_axi_wready,
  input  logic       i_m_axi_bvalid,
  output logic       o_m_axi_bready,
  output xlen_t      o_m_axi_araddr,
  output logic       o_m_axi_arvalid,
  input  logic       i_m_axi_arready,
  output logic [7:0] o_m_axi_arlen,
  output logic [2:0] o_m_axi_arsize,
  output logic [1:0] o_m_axi_arburst,
  input  xlen_t      i_m_axi_rdata,
  input  logic       i_m_axi_rlast,
  input  logic       i_m_axi_rvalid,
  output logic       o_m_axi_rready
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WADDR,
    ST_BRESP,
    ST_RADDR,
    ST_RDATA
  } lsu_state_e;

  lsu_state_e state;
  xlen_t      addr_q;
  xlen_t      wdata_q;
  logic [3:0] strb_q;
  logic [1:0] off_q;
  mem_op_e    op_q;
  xlen_t      wdata_d;
  logic [3:0] strb_d;
  xlen_t      lane;

  // replicate the store data so every lane carries it
  always_comb begin
    case (i_op)
      SB: begin
        wdata_d = {4{i_wdata[7:0]}};
        strb_d  = 4'b0001 << i_addr[1:0];
      end
      SH: begin
        wdata_d = {2{i_wdata[15:0]}};
        strb_d  = 4'b0011 << {i_addr[1], 1'b0};
      end
      default: begin
        wdata_d = i_wdata;
        strb_d  = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (i_req && state == ST_IDLE) begin
      addr_q  <= {i_addr[XLEN-1:2], 2'b00};
      off_q   <= i_addr[1:0];
      op_q    <= i_op;
      wdata_q <= wdata_d;
      strb_q  <= strb_d;
    end
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state           <= ST_IDLE;
      o_m_axi_awvalid <= 1'b0;
      o_m_axi_wvalid  <= 1'b0;
      o_m_axi_arvalid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_req && is_store(i_op)) begin
            o_m_axi_awvalid <= 1'b1;
            o_m_axi_wvalid  <= 1'b1;
            state           <= ST_WADDR;
          end else if (i_req && is_load(i_op)) begin
            o_m_axi_arvalid <= 1'b1;
            state           <= ST_RADDR;
          end
        end
        ST_WADDR: begin
          // aw and w may be taken on different cycles
          if (i_m_axi_awready) begin
            o_m_axi_awvalid <= 1'b0;
          end
          if (i_m_axi_wready) begin
            o_m_axi_wvalid <= 1'b0;
          end
          if ((!o_m_axi_awvalid || i_m_axi_awready) && (!o_m_axi_wvalid || i_m_axi_wready)) begin
            state <= ST_BRESP;
          end
        end
        ST_BRESP: begin
          if (i_m_axi_bvalid) begin
            state <= ST_IDLE;
          end
        end
        ST_RADDR: begin
          if (i_m_axi_arready) begin
            o_m_axi_arvalid <= 1'b0;
            state           <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (i_m_axi_rvalid && i_m_axi_rlast) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign o_m_axi_awaddr  = addr_q;
  assign o_m_axi_araddr  = addr_q;
  assign o_m_axi_awlen   = AXI_LEN_SINGLE;
  assign o_m_axi_arlen   = AXI_LEN_SINGLE;
  assign o_m_axi_awsize  = AXI_SIZE_WORD;
  assign o_m_axi_arsize  = AXI_SIZE_WORD;
  assign o_m_axi_awburst = AXI_BURST_INCR;
  assign o_m_axi_arburst = AXI_BURST_INCR;
  assign o_m_axi_wdata   = wdata_q;
  assign o_m_axi_wstrb   = strb_q;
  assign o_m_axi_wlast   = 1'b1;
  assign o_m_axi_bready  = state == ST_BRESP;
  assign o_m_axi_rready  = state == ST_RDATA;

  assign o_done = (state == ST_BRESP && i_m_axi_bvalid) ||
                  (state == ST_RDATA && i_m_axi_rvalid && i_m_axi_rlast);

  // move the addressed byte or half down to bit 0
  assign lane = i_m_axi_rdata >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      o_rdata = {{24{lane[7]}}, lane[7:0]};
      LBU:     o_rdata = {24'b0, lane[7:0]};
      LH:      o_rdata = {{16{lane[15]}}, lane[15:0]};
      LHU:     o_rdata = {16'b0, lane[15:0]};
      default: o_rdata = lane;
    endcase
  end

endmodule

`default_nettype wire

/* src/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_op_e;

  // same values as the RV32I branch funct3
  typedef enum logic [2:0] {
    BEQ     = 3'd0,
    BNE     = 3'd1,
    BR_NONE = 3'd2,
    BLT     = 3'd4,
    BGE     = 3'd5,
    BLTU    = 3'd6,
    BGEU    = 3'd7
  } brch_op_e;

  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    LB       = 4'd1,
    LH       = 4'd2,
    LW       = 4'd3,
    LBU      = 4'd4,
    LHU      = 4'd5,
    SB       = 4'd6,
    SH       = 4'd7,
    SW       = 4'd8
  } mem_op_e;

  // operand pairs src1/src2, src1/imm, pc/4 and pc/imm
  typedef enum logic [1:0] {
    SEL_REG = 2'd0,
    SEL_IMM = 2'd1,
    SEL_PC4 = 2'd2,
    SEL_PCI = 2'd3
  } src_sel_e;

  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
  localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  function automatic logic is_load(mem_op_e op);
    return op inside {LB, LH, LW, LBU, LHU};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {SB, SH, SW};
  endfunction

endpackage

`default_nettype wire

/* src/exu_stage.sv */
`default_nettype none

module exu_stage import exu_pkg::*; (
  input  logic       clock,
  input  logic       i_rst_n,
  input  logic       i_in_valid,
  output logic       o_in_ready,
  input  xlen_t      i_src1,
  input  xlen_t      i_src2,
  input  xlen_t      i_pc,
  input  xlen_t      i_imm,
  input  alu_op_e    i_alu_op,
  input  brch_op_e   i_brch_op,
  input  mem_op_e    i_mem_op,
  input  src_sel_e   i_src_sel,
  output logic       o_out_valid,
  input  logic       i_out_ready,
  output xlen_t      o_res,
  output logic       o_zero,
  output xlen_t      o_m_axi_awaddr,
  output logic       o_m_axi_awvalid,
  input  logic       i_m_axi_awready,
  output logic [7:0] o_m_axi_awlen,
  output logic [2:0] o_m_axi_awsize,
  output logic [1:0] o_m_axi_awburst,
  output xlen_t      o_m_axi_wdata,
  output logic [3:0] o_m_axi_wstrb,
  output logic       o_m_axi_wlast,
  output logic       o_m_axi_wvalid,
  input  logic       i_m_axi_wready,
  input  logic       i_m_axi_bvalid,
  output logic       o_m_axi_bready,
  output xlen_t      o_m_axi_araddr,
  output logic       o_m_axi_arvalid,
  input  logic       i_m_axi_arready,
  output logic [7:0] o_m_axi_arlen,
  output logic [2:0] o_m_axi_arsize,
  output logic [1:0] o_m_axi_arburst,
  input  xlen_t      i_m_axi_rdata,
  input  logic       i_m_axi_rlast,
  input  logic       i_m_axi_rvalid,
  output logic       o_m_axi_rready
);

  typedef enum logic [2:0] {
    ST_INIT,
    ST_IDLE,
    ST_LSU_REQ,
    ST_LSU_WAIT,
    ST_OUT
  } stage_state_e;

  stage_state_e state;
  xlen_t        src1_q;
  xlen_t        src2_q;
  xlen_t        pc_q;
  xlen_t        imm_q;
  alu_op_e      alu_op_q;
  brch_op_e     brch_op_q;
  mem_op_e      mem_op_q;
  src_sel_e     sel_q;
  xlen_t        alu_a;
  xlen_t        alu_b;
  xlen_t        alu_res;
  logic         alu_lt;
  logic         alu_ltu;
  logic         taken;
  logic         lsu_req;
  logic         lsu_done;
  xlen_t        lsu_rdata;
  xlen_t        load_q;
  logic         accept;

  assign o_in_ready  = state == ST_IDLE;
  assign o_out_valid = state == ST_OUT;
  assign accept      = i_in_valid && o_in_ready;
  assign lsu_req     = state == ST_LSU_REQ;

  always_ff @(posedge clock) begin
    if (accept) begin
      src1_q    <= i_src1;
      src2_q    <= i_src2;
      pc_q      <= i_pc;
      imm_q     <= i_imm;
      alu_op_q  <= i_alu_op;
      brch_op_q <= i_brch_op;
      mem_op_q  <= i_mem_op;
      sel_q     <= i_src_sel;
    end
    if (lsu_done) begin
      load_q <= lsu_rdata;
    end
  end

  // alu and branch results are ready straight after acceptance
  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_INIT;
    end else begin
      case (state)
        ST_INIT:     state <= ST_IDLE;
        ST_IDLE:     if (accept) state <= (i_mem_op == MEM_NONE) ? ST_OUT : ST_LSU_REQ;
        ST_LSU_REQ:  state <= ST_LSU_WAIT;
        ST_LSU_WAIT: if (lsu_done) state <= ST_OUT;
        ST_OUT:      if (i_out_ready) state <= ST_IDLE;
        default:     state <= ST_IDLE;
      endcase
    end
  end

  assign alu_a = (sel_q == SEL_PC4 || sel_q == SEL_PCI) ? pc_q : src1_q;

  always_comb begin
    case (sel_q)
      SEL_REG: alu_b = src2_q;
      SEL_PC4: alu_b = 32'd4;
      default: alu_b = imm_q;
    endcase
  end

  exu_alu alu_i (
    .i_a   (alu_a),
    .i_b   (alu_b),
    .i_op  (alu_op_q),
    .o_res (alu_res),
    .o_lt  (alu_lt),
    .o_ltu (alu_ltu)
  );

  // branches run the alu as a subtract
  always_comb begin
    case (brch_op_q)
      BEQ:     taken = alu_res == '0;
      BNE:     taken = alu_res != '0;
      BLT:     taken = alu_lt;
      BGE:     taken = !alu_lt;
      BLTU:    taken = alu_ltu;
      BGEU:    taken = !alu_ltu;
      default: taken = 1'b0;
    endcase
  end

  exu_lsu lsu_i (
    .i_req   (lsu_req),
    .i_addr  (alu_res),
    .i_wdata (src2_q),
    .i_op    (mem_op_q),
    .o_done  (lsu_done),
    .o_rdata (lsu_rdata),
    .*
  );

  always_comb begin
    if (is_load(mem_op_q)) begin
      o_res = load_q;
    end else if (brch_op_q != BR_NONE && mem_op_q == MEM_NONE) begin
      o_res = {{(XLEN-1){1'b0}}, taken};
    end else begin
      // stores return their address, which is the alu sum
      o_res = alu_res;
    end
  end

  assign o_zero = o_res == '0;

endmodule

`default_nettype wire

/* src/exu_top.sv */
`default_nettype none

module exu_top import exu_pkg::*; #(
  parameter int ADDR_W      = 10,
  parameter int RAM_LATENCY = 1
) (
  input  logic     clock,
  input  logic     i_rst_n,
  input  logic     i_in_valid,
  output logic     o_in_ready,
  input  xlen_t    i_src1,
  input  xlen_t    i_src2,
  input  xlen_t    i_pc,
  input  xlen_t    i_imm,
  input  alu_op_e  i_alu_op,
  input  brch_op_e i_brch_op,
  input  mem_op_e  i_mem_op,
  input  src_sel_e i_src_sel,
  output logic     o_out_valid,
  input  logic     i_out_ready,
  output xlen_t    o_res,
  output logic     o_zero
);

  xlen_t      awaddr;
  xlen_t      wdata;
  xlen_t      araddr;
  xlen_t      rdata;
  logic [3:0] wstrb;
  logic       awvalid, awready;
  logic       wvalid, wready;
  logic       bvalid, bready;
  logic       arvalid, arready;
  logic       rvalid, rready, rlast;

  // the ram ignores len, size, burst and wlast of single beats
  exu_stage stage_i (
    .clock           (clock),
    .i_rst_n         (i_rst_n),
    .i_in_valid      (i_in_valid),
    .o_in_ready      (o_in_ready),
    .i_src1          (i_src1),
    .i_src2          (i_src2),
    .i_pc            (i_pc),
    .i_imm           (i_imm),
    .i_alu_op        (i_alu_op),
    .i_brch_op       (i_brch_op),
    .i_mem_op        (i_mem_op),
    .i_src_sel       (i_src_sel),
    .o_out_valid     (o_out_valid),
    .i_out_ready     (i_out_ready),
    .o_res           (o_res),
    .o_zero          (o_zero),
    .o_m_axi_awaddr  (awaddr),
    .o_m_axi_awvalid (awvalid),
    .i_m_axi_awready (awready),
    .o_m_axi_awlen   (),
    .o_m_axi_awsize  (),
    .o_m_axi_awburst (),
    .o_m_axi_wdata   (wdata),
    .o_m_axi_wstrb   (wstrb),
    .o_m_axi_wlast   (),
    .o_m_axi_wvalid  (wvalid),
    .i_m_axi_wready  (wready),
    .i_m_axi_bvalid  (bvalid),
    .o_m_axi_bready  (bready),
    .o_m_axi_araddr  (araddr),
    .o_m_axi_arvalid (arvalid),
    .i_m_axi_arready (arready),
    .o_m_axi_arlen   (),
    .o_m_axi_arsize  (),
    .o_m_axi_arburst (),
    .i_m_axi_rdata   (rdata),
    .i_m_axi_rlast   (rlast),
    .i_m_axi_rvalid  (rvalid),
    .o_m_axi_rready  (rready)
  );

  exu_data_ram #(
    .ADDR_W      (ADDR_W),
    .RAM_LATENCY (RAM_LATENCY)
  ) ram_i (
    .clock           (clock),
    .i_rst_n         (i_rst_n),
    .i_s_axi_awaddr  (awaddr),
    .i_s_axi_awvalid (awvalid),
    .o_s_axi_awready (awready),
    .i_s_axi_wdata   (wdata),
    .i_s_axi_wstrb   (wstrb),
    .i_s_axi_wvalid  (wvalid),
    .o_s_axi_wready  (wready),
    .o_s_axi_bvalid  (bvalid),
    .i_s_axi_bready  (bready),
    .i_s_axi_araddr  (araddr),
    .i_s_axi_arvalid (arvalid),
    .o_s_axi_arready (arready),
    .o_s_axi_rdata   (rdata),
    .o_s_axi_rlast   (rlast),
    .o_s_axi_rvalid  (rvalid),
    .i_s_axi_rready  (rready)
  );

endmodule

`default_nettype wire
